/* hw/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                           clk,
    input  logic                           rst_n,

    // entry queue read side
    input  i2c_pkg::i2c_entry_t            head_i,
    input  logic                           empty_i,
    output logic                           pop_o,

    input  logic [i2c_pkg::PRESCALE_W-1:0] prescale_i,

    // open-drain pins, 1 releases the line
    input  logic                           sda_i,
    output logic                           scl_o,
    output logic                           sda_o,

    i2c_status_if.engine                   status
);

    i2c_pkg::engine_state_e         state;
    logic [i2c_pkg::PRESCALE_W-1:0] q_cnt;
    logic [1:0]                     phase;
    logic [2:0]                     bit_cnt;
    logic [7:0]                     shift_q;
    logic [6:0]                     last_addr_q;
    // current byte is the address byte
    logic                           addr_phase;
    logic                           missed_q;
    logic                           scl_q;
    logic                           sda_q;
    logic                           scl_d;
    logic                           sda_d;
    logic                           in_xfer;
    logic                           tick;
    logic                           ph_end;
    logic                           hold_same;
    logic                           load_data;

    // states that run the quarter timer
    assign in_xfer = (state == i2c_pkg::ST_START) || (state == i2c_pkg::ST_BIT)
                     || (state == i2c_pkg::ST_ACK) || (state == i2c_pkg::ST_STOP);
    // >= so a lowered prescale cannot strand the counter
    assign tick    = (q_cnt >= prescale_i);
    assign ph_end  = tick && (phase == 2'd3);

    // same target while holding, no restart needed
    assign hold_same = (state == i2c_pkg::ST_HOLD) && !empty_i
                       && (head_i.op == i2c_pkg::OP_WRITE) && (head_i.addr == last_addr_q);
    assign load_data = hold_same || ((state == i2c_pkg::ST_ACK) && ph_end && addr_phase);

    // stop with bus free, end of data ack, end of stop
    assign pop_o = ((state == i2c_pkg::ST_IDLE) && !empty_i && (head_i.op == i2c_pkg::OP_STOP))
                   || ((state == i2c_pkg::ST_ACK) && ph_end && !addr_phase)
                   || ((state == i2c_pkg::ST_STOP) && ph_end);

    // pin levels per quarter
    // each quarter moves one line only, the other keeps its last value
    always_comb begin
        scl_d = scl_q;
        sda_d = sda_q;
        unique case (state)
            i2c_pkg::ST_IDLE: begin
                scl_d = 1'b1;
                sda_d = 1'b1;
            end
            i2c_pkg::ST_HOLD: begin
                scl_d = 1'b0;
            end
            i2c_pkg::ST_START: begin
                // sda up, scl up, sda down, scl down
                case (phase)
                    2'd0: sda_d = 1'b1;
                    2'd1: scl_d = 1'b1;
                    2'd2: sda_d = 1'b0;
                    default: scl_d = 1'b0;
                endcase
            end
            i2c_pkg::ST_BIT, i2c_pkg::ST_ACK: begin
                // data set while scl low, ack bit released
                case (phase)
                    2'd0: sda_d = (state == i2c_pkg::ST_BIT) ? shift_q[7] : 1'b1;
                    2'd3: scl_d = 1'b0;
                    default: scl_d = 1'b1;
                endcase
            end
            i2c_pkg::ST_STOP: begin
                // sda low, scl up, then sda rises with scl high
                case (phase)
                    2'd0: sda_d = 1'b0;
                    2'd1: scl_d = 1'b1;
                    default: sda_d = 1'b1;
                endcase
            end
            default: begin
                scl_d = 1'b1;
                sda_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= i2c_pkg::ST_IDLE;
            q_cnt      <= '0;
            phase      <= 2'd0;
            bit_cnt    <= 3'd0;
            addr_phase <= 1'b0;
            missed_q   <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
        end else begin
            missed_q <= 1'b0;
            scl_q    <= scl_d;
            sda_q    <= sda_d;

            // quarter timer, parked at zero when waiting
            if (!in_xfer) begin
                q_cnt <= '0;
                phase <= 2'd0;
            end else if (tick) begin
                q_cnt <= '0;
                phase <= phase + 2'd1;
            end else begin
                q_cnt <= q_cnt + 1'b1;
            end

            unique case (state)
                i2c_pkg::ST_IDLE: begin
                    // a stop here is only popped
                    if (!empty_i && head_i.op == i2c_pkg::OP_WRITE) begin
                        state <= i2c_pkg::ST_START;
                    end
                end
                i2c_pkg::ST_HOLD: begin
                    if (!empty_i) begin
                        if (head_i.op == i2c_pkg::OP_STOP) begin
                            state <= i2c_pkg::ST_STOP;
                        end else if (hold_same) begin
                            state      <= i2c_pkg::ST_BIT;
                            addr_phase <= 1'b0;
                        end else begin
                            // new target, repeated start
                            state <= i2c_pkg::ST_START;
                        end
                    end
                end
                i2c_pkg::ST_START: begin
                    if (ph_end) begin
                        state      <= i2c_pkg::ST_BIT;
                        addr_phase <= 1'b1;
                    end
                end
                i2c_pkg::ST_BIT: begin
                    if (ph_end) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= i2c_pkg::ST_ACK;
                        end
                    end
                end
                i2c_pkg::ST_ACK: begin
                    // sample mid scl-high
                    if (tick && phase == 2'd2 && sda_i) begin
                        missed_q <= 1'b1;
                    end
                    if (ph_end) begin
                        state      <= addr_phase ? i2c_pkg::ST_BIT : i2c_pkg::ST_HOLD;
                        addr_phase <= 1'b0;
                    end
                end
                i2c_pkg::ST_STOP: begin
                    if (ph_end) begin
                        state <= i2c_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= i2c_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // shift register and last target
    always_ff @(posedge clk) begin
        if ((state == i2c_pkg::ST_START) && ph_end) begin
            // address byte, r/w bit 0 for write
            shift_q     <= {head_i.addr, 1'b0};
            last_addr_q <= head_i.addr;
        end else if (load_data) begin
            shift_q <= head_i.data;
        end else if ((state == i2c_pkg::ST_BIT) && ph_end) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign scl_o = scl_q;
    assign sda_o = sda_q;

    // pending entries count as busy
    assign status.busy        = in_xfer || !empty_i;
    assign status.bus_control = (state != i2c_pkg::ST_IDLE);
    // sda held low by someone else also means active
    assign status.bus_active  = (state != i2c_pkg::ST_IDLE) || !sda_i;
    assign status.missed_ack  = missed_q;

    // sda moves only while scl is steady
    a_scl_sda_apart: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(sda_o) |-> $stable(scl_o)
    );

endmodule

/* hw/i2c_entry_fifo.sv */
`timescale 1ns/1ps

module i2c_entry_fifo #(
    parameter int FIFO_ADDR_W = 2
) (
    input  logic                clk,
    input  logic                rst_n,

    // write side, from the register block
    input  logic                push_i,
    input  i2c_pkg::i2c_entry_t entry_i,

    // read side, to the bit engine
    input  logic                pop_i,
    output i2c_pkg::i2c_entry_t head_o,
    output logic                empty_o,
    output logic                full_o
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;

    i2c_pkg::i2c_entry_t    mem [DEPTH];
    // extra msb tells full from empty
    logic [FIFO_ADDR_W:0]   wr_ptr;
    logic [FIFO_ADDR_W:0]   rd_ptr;
    logic                   wr_en;
    logic                   rd_en;

    assign empty_o = (wr_ptr == rd_ptr);
    // same slot, opposite lap
    assign full_o  = (wr_ptr == {~rd_ptr[FIFO_ADDR_W], rd_ptr[FIFO_ADDR_W-1:0]});

    // pushes while full are dropped
    assign wr_en = push_i && !full_o;
    assign rd_en = pop_i && !empty_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= entry_i;
        end
    end

    // head is read without a register
    assign head_o = mem[rd_ptr[FIFO_ADDR_W-1:0]];

    // the engine only pops an entry it is looking at
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
    );

endmodule

/* hw/i2c_host_regs.sv */
`timescale 1ns/1ps

module i2c_host_regs #(
    parameter int unsigned DEFAULT_PRESCALE = 40
) (
    input  logic                               clk,
    input  logic                               rst_n,

    // host bus
    input  logic [2:0]                         adr_i,
    input  logic [7:0]                         dat_i,
    input  logic                               we_i,
    input  logic                               stb_i,
    input  logic                               cyc_i,
    output logic [7:0]                         dat_o,
    output logic                               ack_o,

    // entry queue write side
    output logic                               push_o,
    output i2c_pkg::i2c_entry_t                entry_o,
    input  logic                               full_i,
    input  logic                               empty_i,

    // engine config and status
    output logic [i2c_pkg::PRESCALE_W-1:0]     prescale_o,
    i2c_status_if.host                         status
);

    logic                           host_cyc;
    logic                           wr_beat;
    logic                           rd_beat;
    logic                           ack_q;
    logic [7:0]                     dat_q;
    logic [7:0]                     rd_data;
    logic [6:0]                     addr_q;
    logic [i2c_pkg::PRESCALE_W-1:0] prescale_q;
    logic                           missed_q;
    logic                           overflow_q;

    assign host_cyc = cyc_i && stb_i;
    // only the first beat of a cycle has side effects
    // ack alternates, so a held strobe gives one beat with ack low
    assign wr_beat  = host_cyc && we_i && !ack_q;
    assign rd_beat  = host_cyc && !we_i && !ack_q;

    // data writes queue a byte, command writes queue a stop
    assign push_o = wr_beat && ((adr_i == i2c_pkg::REG_DATA)
                    || (adr_i == i2c_pkg::REG_CMD && dat_i[i2c_pkg::CMD_STOP_BIT]));

    always_comb begin
        entry_o.op   = (adr_i == i2c_pkg::REG_DATA) ? i2c_pkg::OP_WRITE : i2c_pkg::OP_STOP;
        // target address taken at push time
        entry_o.addr = addr_q;
        entry_o.data = dat_i;
    end

    // read mux
    always_comb begin
        rd_data = 8'h00;
        case (adr_i)
            i2c_pkg::REG_STATUS: begin
                rd_data = {4'h0, missed_q, status.bus_active,
                           status.bus_control, status.busy};
            end
            i2c_pkg::REG_QSTATUS: begin
                rd_data = {5'h00, overflow_q, full_i, empty_i};
            end
            i2c_pkg::REG_ADDR: begin
                rd_data = {1'b0, addr_q};
            end
            i2c_pkg::REG_PRE_LO: begin
                rd_data = prescale_q[7:0];
            end
            i2c_pkg::REG_PRE_HI: begin
                rd_data = prescale_q[i2c_pkg::PRESCALE_W-1:8];
            end
            // data and command read back as zero
            default: begin
                rd_data = 8'h00;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            dat_q      <= 8'h00;
            addr_q     <= 7'h00;
            prescale_q <= DEFAULT_PRESCALE[i2c_pkg::PRESCALE_W-1:0];
            missed_q   <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            ack_q <= host_cyc && !ack_q;
            // latched on the first beat, shown while ack is high
            dat_q <= rd_beat ? rd_data : 8'h00;

            if (wr_beat) begin
                case (adr_i)
                    i2c_pkg::REG_ADDR: begin
                        addr_q <= dat_i[6:0];
                    end
                    i2c_pkg::REG_PRE_LO: begin
                        prescale_q[7:0] <= dat_i;
                    end
                    i2c_pkg::REG_PRE_HI: begin
                        prescale_q[i2c_pkg::PRESCALE_W-1:8] <= dat_i;
                    end
                    default: begin
                    end
                endcase
            end

            // sticky, cleared by a status read
            // a pulse landing on the read beat is kept
            if (rd_beat && adr_i == i2c_pkg::REG_STATUS) begin
                missed_q <= status.missed_ack;
            end else begin
                missed_q <= missed_q || status.missed_ack;
            end

            // the queue drops pushes while full
            if (rd_beat && adr_i == i2c_pkg::REG_QSTATUS) begin
                overflow_q <= 1'b0;
            end else if (push_o && full_i) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign ack_o      = ack_q;
    assign dat_o      = dat_q;
    assign prescale_o = prescale_q;

    // queue flags feed overflow and QSTATUS, never both set
    a_queue_flags_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(full_i && empty_i)
    );

    // engine timing depends on a defined prescale
    a_prescale_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(prescale_o)
    );

endmodule

/* hw/i2c_pkg.sv */
package i2c_pkg;

    // queue entry opcodes
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_STOP  = 1'b1
    } i2c_op_e;

    // one queue slot, 16 bits
    typedef struct packed {
        i2c_op_e    op;
        logic [6:0] addr;
        logic [7:0] data;
    } i2c_entry_t;

    // bit engine FSM
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        // start or repeated start
        ST_START = 3'd1,
        // shifting out one of 8 bits
        ST_BIT   = 3'd2,
        // ninth clock, slave drives sda
        ST_ACK   = 3'd3,
        ST_STOP  = 3'd4,
        // bus owned, scl parked low between entries
        ST_HOLD  = 3'd5
    } engine_state_e;

    // host register map
    localparam logic [2:0] REG_STATUS  = 3'd0;
    localparam logic [2:0] REG_QSTATUS = 3'd1;
    localparam logic [2:0] REG_ADDR    = 3'd2;
    localparam logic [2:0] REG_CMD     = 3'd3;
    localparam logic [2:0] REG_DATA    = 3'd4;
    // address 5 reserved
    localparam logic [2:0] REG_PRE_LO  = 3'd6;
    localparam logic [2:0] REG_PRE_HI  = 3'd7;

    // command register bits
    localparam int CMD_STOP_BIT = 4;

    // quarter period length in clk cycles, minus one
    localparam int PRESCALE_W = 16;

endpackage

/* hw/i2c_status_if.sv */
`timescale 1ns/1ps

interface i2c_status_if;

    // transfer in progress or entries pending
    logic busy;
    // engine owns the bus
    logic bus_control;
    // bus not idle, whoever holds it
    logic bus_active;
    // one-cycle pulse per nacked byte
    logic missed_ack;

    modport engine (
        output busy,
        output bus_control,
        output bus_active,
        output missed_ack
    );

    modport host (
        input busy,
        input bus_control,
        input bus_active,
        input missed_ack
    );

endinterface

/* hw/i2c_wr_master.sv */
`timescale 1ns/1ps

module i2c_wr_master #(
    parameter int unsigned DEFAULT_PRESCALE = 40,
    parameter int          FIFO_ADDR_W      = 2
) (
    input  logic       clk,
    input  logic       rst_n,

    // host bus
    input  logic [2:0] adr_i,
    input  logic [7:0] dat_i,
    input  logic       we_i,
    input  logic       stb_i,
    input  logic       cyc_i,
    output logic [7:0] dat_o,
    output logic       ack_o,

    // i2c pins, open drain
    input  logic       sda_i,
    output logic       scl_o,
    output logic       sda_o
);

    logic                           push;
    i2c_pkg::i2c_entry_t            entry;
    i2c_pkg::i2c_entry_t            head;
    logic                           full;
    logic                           empty;
    logic                           pop;
    logic [i2c_pkg::PRESCALE_W-1:0] prescale;

    i2c_status_if status_if ();

    // producer
    i2c_host_regs #(
        .DEFAULT_PRESCALE(DEFAULT_PRESCALE)
    ) u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .adr_i      (adr_i),
        .dat_i      (dat_i),
        .we_i       (we_i),
        .stb_i      (stb_i),
        .cyc_i      (cyc_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .push_o     (push),
        .entry_o    (entry),
        .full_i     (full),
        .empty_i    (empty),
        .prescale_o (prescale),
        .status     (status_if.host)
    );

    // write and stop entries
    i2c_entry_fifo #(
        .FIFO_ADDR_W(FIFO_ADDR_W)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (push),
        .entry_i (entry),
        .pop_i   (pop),
        .head_o  (head),
        .empty_o (empty),
        .full_o  (full)
    );

    // consumer
    i2c_bit_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_i     (head),
        .empty_i    (empty),
        .pop_o      (pop),
        .prescale_i (prescale),
        .sda_i      (sda_i),
        .scl_o      (scl_o),
        .sda_o      (sda_o),
        .status     (status_if.engine)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_i2c_wr_master -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1

/* src.f */
hw/i2c_pkg.sv
hw/i2c_status_if.sv
hw/i2c_host_regs.sv
hw/i2c_entry_fifo.sv
hw/i2c_bit_engine.sv
hw/i2c_wr_master.sv
verif/tb_i2c_wr_master.sv

/* verif/tb_i2c_wr_master.sv */
`timescale 1ns/1ps

module tb_i2c_wr_master;

    localparam int unsigned PRESCALE_DEFAULT = 40;
    localparam int          QUEUE_ADDR_W     = 2;
    localparam logic [7:0]  FAST_PRESCALE    = 8'h09;
    // two passes over 6 bytes of 9 bits at the reset prescale, plus polling slack
    localparam int TIMEOUT_CYCLES = 2 * 6 * 9 * 4 * (PRESCALE_DEFAULT + 1) + 2000;

    // slave log codes, bytes use the low 8 bits
    localparam logic [9:0] EV_START   = 10'h100;
    localparam logic [9:0] EV_STOP    = 10'h200;
    localparam logic [6:0] SLAVE_ADDR = 7'h50;

    logic       clk;
    logic       rst_n;
    logic [2:0] adr_i;
    logic [7:0] dat_i;
    logic       we_i;
    logic       stb_i;
    logic       cyc_i;
    logic [7:0] dat_o;
    logic       ack_o;
    logic       scl_o;
    logic       sda_o;
    logic       slave_sda;
    wire        bus_sda;

    int         errors;
    int         checks;
    int         cycle_cnt;

    logic [9:0] bus_log [$];
    logic [9:0] exp_log [$];
    logic [7:0] rx_byte;
    int         rx_bits;
    logic       first_byte;
    logic       selected;

    // open-drain wired and
    assign bus_sda = sda_o & slave_sda;

    i2c_wr_master #(
        .DEFAULT_PRESCALE(PRESCALE_DEFAULT),
        .FIFO_ADDR_W     (QUEUE_ADDR_W)
    ) DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .adr_i (adr_i),
        .dat_i (dat_i),
        .we_i  (we_i),
        .stb_i (stb_i),
        .cyc_i (cyc_i),
        .dat_o (dat_o),
        .ack_o (ack_o),
        .sda_i (bus_sda),
        .scl_o (scl_o),
        .sda_o (sda_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // slave model
    // start, sda falls with scl high
    always @(negedge bus_sda) begin
        if (scl_o === 1'b1) begin
            bus_log.push_back(EV_START);
            rx_bits    = 0;
            first_byte = 1'b1;
        end
    end

    // stop, sda rises with scl high
    always @(posedge bus_sda) begin
        if (scl_o === 1'b1) begin
            bus_log.push_back(EV_STOP);
            selected = 1'b0;
        end
    end

    always @(posedge scl_o) begin
        if (rx_bits < 8) begin
            rx_byte = {rx_byte[6:0], bus_sda};
        end
        rx_bits++;
    end

    // ack driven and released while scl is low
    always @(negedge scl_o) begin
        if (rx_bits == 8) begin
            bus_log.push_back({2'b00, rx_byte});
            if (first_byte) begin
                selected = (rx_byte[7:1] == SLAVE_ADDR);
            end
            if (selected) begin
                slave_sda = 1'b0;
            end
        end else if (rx_bits == 9) begin
            slave_sda  = 1'b1;
            rx_bits    = 0;
            first_byte = 1'b0;
        end
    end

    task automatic check_eq(input string name, input logic [9:0] got, input logic [9:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // host cycle, called at posedge+2, returns at posedge+2
    task automatic bus_cycle(input logic [2:0] a, input logic [7:0] d, input logic we,
                             output logic [7:0] rd);
        int n;
        adr_i = a;
        dat_i = d;
        we_i  = we;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        n     = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (ack_o !== 1'b1 && n < 8);
        checks++;
        assert (ack_o === 1'b1) else begin
            errors++;
            $display("host cycle to register %0d got no ack", a);
        end
        rd = dat_o;
        #1;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] a, input logic [7:0] d);
        logic [7:0] unused;
        bus_cycle(a, d, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [2:0] a, output logic [7:0] d);
        bus_cycle(a, 8'h00, 1'b0, d);
    endtask

    task automatic expect_reg(input logic [2:0] a, input logic [7:0] exp, input string name);
        logic [7:0] d;
        bus_read(a, d);
        check_eq({"dat_o ", name}, {2'b00, d}, {2'b00, exp});
    endtask

    // polls the queue status, status reads would clear missed-ack
    task automatic wait_queue(input logic [7:0] mask, input logic [7:0] want);
        logic [7:0] q;
        bus_read(i2c_pkg::REG_QSTATUS, q);
        while ((q & mask) != want) begin
            bus_read(i2c_pkg::REG_QSTATUS, q);
        end
    endtask

    task automatic check_log();
        int i;
        check_eq("bus_log size", 10'(bus_log.size()), 10'(exp_log.size()));
        for (i = 0; i < exp_log.size() && i < bus_log.size(); i++) begin
            check_eq($sformatf("bus_log[%0d]", i), bus_log[i], exp_log[i]);
        end
        bus_log.delete();
        exp_log.delete();
    endtask

    task automatic test_reset_values();
        expect_reg(i2c_pkg::REG_STATUS, 8'h00, "REG_STATUS");
        // only empty set
        expect_reg(i2c_pkg::REG_QSTATUS, 8'h01, "REG_QSTATUS");
        expect_reg(i2c_pkg::REG_PRE_LO, 8'(PRESCALE_DEFAULT), "REG_PRE_LO");
        expect_reg(i2c_pkg::REG_PRE_HI, 8'(PRESCALE_DEFAULT >> 8), "REG_PRE_HI");
    endtask

    task automatic test_prescale();
        bus_write(i2c_pkg::REG_PRE_LO, FAST_PRESCALE);
        bus_write(i2c_pkg::REG_PRE_HI, 8'h00);
        expect_reg(i2c_pkg::REG_PRE_LO, FAST_PRESCALE, "REG_PRE_LO");
        expect_reg(i2c_pkg::REG_PRE_HI, 8'h00, "REG_PRE_HI");
    endtask

    task automatic test_write_transfer();
        bus_log.delete();
        bus_write(i2c_pkg::REG_ADDR, 8'h50);
        bus_write(i2c_pkg::REG_DATA, 8'h3c);
        bus_write(i2c_pkg::REG_DATA, 8'hc5);
        bus_write(i2c_pkg::REG_CMD, 8'h10);
        wait_queue(8'h01, 8'h01);
        exp_log.push_back(EV_START);
        // address byte, write bit 0
        exp_log.push_back(10'h0a0);
        exp_log.push_back(10'h03c);
        exp_log.push_back(10'h0c5);
        exp_log.push_back(EV_STOP);
        check_log();
        expect_reg(i2c_pkg::REG_STATUS, 8'h00, "REG_STATUS");
    endtask

    task automatic test_repeated_start();
        bus_log.delete();
        bus_write(i2c_pkg::REG_ADDR, 8'h50);
        bus_write(i2c_pkg::REG_DATA, 8'h11);
        bus_write(i2c_pkg::REG_ADDR, 8'h51);
        bus_write(i2c_pkg::REG_DATA, 8'h22);
        bus_write(i2c_pkg::REG_CMD, 8'h10);
        wait_queue(8'h01, 8'h01);
        exp_log.push_back(EV_START);
        exp_log.push_back(10'h0a0);
        exp_log.push_back(10'h011);
        exp_log.push_back(EV_START);
        // 0x51 is not answered, its data byte still goes out
        exp_log.push_back(10'h0a2);
        exp_log.push_back(10'h022);
        exp_log.push_back(EV_STOP);
        check_log();
        // missed-ack in bit 3, cleared by the read
        expect_reg(i2c_pkg::REG_STATUS, 8'h08, "REG_STATUS");
        expect_reg(i2c_pkg::REG_STATUS, 8'h00, "REG_STATUS");
    endtask

    task automatic test_overflow();
        int i;
        bus_log.delete();
        bus_write(i2c_pkg::REG_ADDR, 8'h50);
        // slowest bus, queue cannot drain
        bus_write(i2c_pkg::REG_PRE_LO, 8'hff);
        bus_write(i2c_pkg::REG_PRE_HI, 8'hff);
        for (i = 0; i < 6; i++) begin
            bus_write(i2c_pkg::REG_DATA, 8'(8'h10 + i));
        end
        // start under way, busy with the bus owned and active
        expect_reg(i2c_pkg::REG_STATUS, 8'h07, "REG_STATUS");
        // full and overflow
        expect_reg(i2c_pkg::REG_QSTATUS, 8'h06, "REG_QSTATUS");
        expect_reg(i2c_pkg::REG_QSTATUS, 8'h02, "REG_QSTATUS");
        bus_write(i2c_pkg::REG_PRE_HI, 8'h00);
        bus_write(i2c_pkg::REG_PRE_LO, FAST_PRESCALE);
        // room for the stop first
        wait_queue(8'h02, 8'h00);
        bus_write(i2c_pkg::REG_CMD, 8'h10);
        wait_queue(8'h01, 8'h01);
        exp_log.push_back(EV_START);
        exp_log.push_back(10'h0a0);
        // last two pushes were dropped
        for (i = 0; i < 4; i++) begin
            exp_log.push_back(10'(10'h010 + i));
        end
        exp_log.push_back(EV_STOP);
        check_log();
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        cycle_cnt  = 0;
        rst_n      = 1'b0;
        adr_i      = 3'd0;
        dat_i      = 8'h00;
        we_i       = 1'b0;
        stb_i      = 1'b0;
        cyc_i      = 1'b0;
        slave_sda  = 1'b1;
        rx_byte    = 8'h00;
        rx_bits    = 0;
        first_byte = 1'b0;
        selected   = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        test_reset_values();
        test_prescale();
        test_write_transfer();
        test_repeated_start();
        test_overflow();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
